/* dv/dot_engine_patterns.txt */
# burst <beats> <acc_init hex> <expected result hex> <ena mode: 0 high, 1 random, 2 stalls>
# Each burst line is followed by an a and a b line per beat, 64 hex digits, element 31 first

burst 2 00000000 00e000e0 0
a 0101010101010101010101010101010101010101010101010101010101010101
b 0202020202020202020202020202020202020202020202020202020202020202
a 0303030303030303030303030303030303030303030303030303030303030303
b 0404040404040404040404040404040404040404040404040404040404040404

burst 1 12345678 f2443688 0
a ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
b ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff

burst 3 0000ffff 1010e01f 1
a 00000000000000000000000000000000ffffffffffffffffffffffffffffffff
b ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
a 0101010101010101010101010101010101010101010101010101010101010101
b 0101010101010101010101010101010101010101010101010101010101010101
a 1010101010101010101010101010101000000000000000000000000000000000
b 1010101010101010101010101010101010101010101010101010101010101010

burst 6 a5a50000 a6f50150 2
a 0101010101010101010101010101010101010101010101010101010101010101
b 0101010101010101010101010101010101010101010101010101010101010101
a 0101010101010101010101010101010101010101010101010101010101010101
b 0202020202020202020202020202020202020202020202020202020202020202
a 0101010101010101010101010101010101010101010101010101010101010101
b 0303030303030303030303030303030303030303030303030303030303030303
a 0101010101010101010101010101010101010101010101010101010101010101
b 0404040404040404040404040404040404040404040404040404040404040404
a 0101010101010101010101010101010101010101010101010101010101010101
b 0505050505050505050505050505050505050505050505050505050505050505
a 0101010101010101010101010101010101010101010101010101010101010101
b 0606060606060606060606060606060606060606060606060606060606060606

burst 2 ffff0001 04670169 1
a 1f1e1d1c1b1a191817161514131211100f0e0d0c0b0a09080706050403020100
b 0101010101010101010101010101010101010101010101010101010101010101
a 0202020202020202020202020202020202020202020202020202020202020202
b 1f1e1d1c1b1a191817161514131211100f0e0d0c0b0a09080706050403020100

/* filelist.f */
src/dot_types_pkg.sv
src/dot_ctrl_pkg.sv
src/dot_half_lane.sv
src/dot_accumulator.sv
src/beat_counter.sv
src/dot_seq_fsm.sv
src/dot_engine_top.sv
dv/dot_engine_tb.sv

/* Bender.yml */
package:
  name: dot_engine

sources:
  - target: any(rtl, test)
    files:
      - src/dot_types_pkg.sv
      - src/dot_ctrl_pkg.sv
      - src/dot_half_lane.sv
      - src/dot_accumulator.sv
      - src/beat_counter.sv
      - src/dot_seq_fsm.sv
      - src/dot_engine_top.sv
  - target: test
    files:
      - dv/dot_engine_tb.sv

/* dv/dot_engine_tb.sv */
// Testbench for the dot-product engine with pattern-file bursts, ena stalls and result checks
`timescale 1ns/1ps
`default_nettype none

module dot_engine_tb;

   // DUT ports
   logic                    clk;
   logic                    arst_n;
   logic                    ena;
   logic                    start;
   dot_ctrl_pkg::beat_cnt_t burst_len;
   dot_types_pkg::acc_t     acc_init;
   dot_types_pkg::vec_t     a_in;
   dot_types_pkg::vec_t     b_in;
   logic                    busy;
   logic                    done;
   dot_types_pkg::acc_t     result;

   // Bursts from the pattern file
   // The vectors of all bursts share one queue
   int                  len_q[$];
   int                  mode_q[$];
   dot_types_pkg::acc_t init_q[$];
   dot_types_pkg::acc_t exp_q[$];
   dot_types_pkg::vec_t a_q[$];
   dot_types_pkg::vec_t b_q[$];

   int          errors = 0;
   int          cycles = 0;
   int          limit = 0;
   int          total_beats = 0;
   int          base;
   int          n;
   int unsigned seed_draw;

   dot_engine_top dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .ena       (ena),
      .start     (start),
      .burst_len (burst_len),
      .acc_init  (acc_init),
      .a_in      (a_in),
      .b_in      (b_in),
      .busy      (busy),
      .done      (done),
      .result    (result)
   );

   // ------------------------------------------------------------------
   // Clock and cycle limit
   // ------------------------------------------------------------------

   always #20 clk = ~clk;

   // The limit stays zero until the pattern file has been read
   always @(posedge clk) begin
      cycles = cycles + 1;
      if ((limit > 0) && (cycles >= limit)) begin
         $display("Timeout after %0d cycles, done never arrived", cycles);
         $display("TESTBENCH FAILED");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   // ------------------------------------------------------------------
   // Checks and helpers
   // ------------------------------------------------------------------

   task automatic check_result(input dot_types_pkg::acc_t got, input dot_types_pkg::acc_t exp,
                               input string what);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "stopping at the first error");
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "stopping at the first error");
      end
   endtask

   // Inputs change and outputs are read 2 ns after the rising edge
   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   // Expected value straight from the rule where each half wraps at 16 bits on its own
   function automatic dot_types_pkg::acc_t accumulate_beat(input dot_types_pkg::acc_t acc,
                                                           input dot_types_pkg::vec_t a,
                                                           input dot_types_pkg::vec_t b);
      logic [15:0] lo;
      logic [15:0] hi;
      logic [15:0] ea;
      logic [15:0] eb;
      int          i;
      lo = acc[15:0];
      hi = acc[31:16];
      for (i = 0; i < 32; i++) begin
         ea = {8'h00, a[8*i +: 8]};
         eb = {8'h00, b[8*i +: 8]};
         if (i < 16) begin
            lo = lo + ea * eb;
         end else begin
            hi = hi + ea * eb;
         end
      end
      return {hi, lo};
   endfunction

   // Mode 0 keeps ena high, mode 1 stalls a quarter of the cycles, mode 2 also forces a stall
   function automatic logic pick_ena(input int mode, input int cyc);
      logic en;
      en = 1'b1;
      if (mode != 0) begin
         en = (($urandom % 4) != 0);
      end
      if ((mode == 2) && (cyc >= 5) && (cyc <= 7)) begin
         en = 1'b0;
      end
      return en;
   endfunction

   task automatic load_patterns();
      int                  fd;
      int                  len;
      int                  mode;
      string               line;
      string               tag;
      dot_types_pkg::acc_t init_v;
      dot_types_pkg::acc_t exp_v;
      dot_types_pkg::vec_t vec;
      fd = $fopen("dv/dot_engine_patterns.txt", "r");
      if (fd == 0) begin
         $display("Could not open the pattern file dv/dot_engine_patterns.txt");
         $display("TESTBENCH FAILED");
         $fatal(1, "no stimulus available");
      end
      while ($fgets(line, fd) > 0) begin
         // Lines starting with # and blank lines carry no data
         if ($sscanf(line, "%s", tag) == 1) begin
            if (tag == "burst") begin
               void'($sscanf(line, "%s %d %h %h %d", tag, len, init_v, exp_v, mode));
               len_q.push_back(len);
               init_q.push_back(init_v);
               exp_q.push_back(exp_v);
               mode_q.push_back(mode);
               total_beats += len;
            end else if (tag == "a") begin
               void'($sscanf(line, "%s %h", tag, vec));
               a_q.push_back(vec);
            end else if (tag == "b") begin
               void'($sscanf(line, "%s %h", tag, vec));
               b_q.push_back(vec);
            end
         end
      end
      $fclose(fd);
      if ((len_q.size() == 0) || (a_q.size() != b_q.size()) || (a_q.size() != total_beats)) begin
         $display("Pattern file has no bursts or its vector count does not match the lengths");
         $display("TESTBENCH FAILED");
         $fatal(1, "bad stimulus file");
      end
   endtask

   // ------------------------------------------------------------------
   // One burst from start to the cycle after done
   // ------------------------------------------------------------------

   task automatic run_burst(input int idx, input int first);
      int                  len;
      int                  mode;
      int                  used;
      int                  cyc;
      int                  lat;
      int                  j;
      logic                en;
      dot_types_pkg::acc_t model;
      len   = len_q[idx];
      mode  = mode_q[idx];
      model = init_q[idx];
      for (j = 0; j < len; j++) begin
         model = accumulate_beat(model, a_q[first+j], b_q[first+j]);
      end
      check_result(model, exp_q[idx], "model against the expected column");
      start     = 1'b1;
      burst_len = dot_ctrl_pkg::beat_cnt_t'(len);
      acc_init  = init_q[idx];
      ena       = pick_ena(mode, 0);
      tick();
      start = 1'b0;
      used  = 0;
      cyc   = 1;
      // A beat counts only on cycles with ena high
      while (used < len) begin
         check_flag(busy, 1'b1, "busy during run");
         check_flag(done, 1'b0, "done during run");
         a_in = a_q[first+used];
         b_in = b_q[first+used];
         en   = pick_ena(mode, cyc);
         ena  = en;
         // A stray start while busy carries a different initial value
         if ((mode == 2) && (cyc == 3)) begin
            start     = 1'b1;
            burst_len = dot_ctrl_pkg::beat_cnt_t'(7);
            acc_init  = ~init_q[idx];
         end
         tick();
         start = 1'b0;
         if (en) begin
            used++;
         end
         cyc++;
      end
      lat = 1;
      while (done !== 1'b1) begin
         check_flag(busy, 1'b1, "busy while draining");
         ena = pick_ena(mode, cyc);
         tick();
         lat++;
         cyc++;
      end
      check_flag(busy, 1'b0, "busy low with done");
      if (mode == 0) begin
         check_flag(lat == 5, 1'b1, "done five clocks after the last beat");
      end
      check_result(result, model, "result at done");
      ena = pick_ena(mode, cyc);
      tick();
      check_flag(done, 1'b0, "done lasts one cycle");
      check_result(result, model, "result held after done");
   endtask

   // ------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      ena       = 1'b0;
      start     = 1'b0;
      burst_len = '0;
      acc_init  = '0;
      a_in      = '0;
      b_in      = '0;
      seed_draw = $urandom(32'ha76c0552);
      load_patterns();
      limit = (total_beats + int'(dot_ctrl_pkg::DRAIN_BEATS) * len_q.size()) * 8 + 100;
      repeat (5) @(posedge clk);
      #2;
      arst_n = 1'b1;
      check_flag(busy, 1'b0, "busy after reset");
      check_flag(done, 1'b0, "done after reset");
      check_result(result, '0, "result after reset");
      // A zero-length start must not load the accumulator or leave IDLE
      start     = 1'b1;
      burst_len = '0;
      acc_init  = 32'h5a5a5a5a;
      ena       = 1'b1;
      tick();
      start = 1'b0;
      tick();
      check_flag(busy, 1'b0, "busy after zero-length start");
      check_result(result, '0, "result after zero-length start");
      base = 0;
      for (n = 0; n < len_q.size(); n++) begin
         run_burst(n, base);
         base += len_q[n];
      end
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src/dot_engine_top.sv */
// Dot-product engine top level wiring the sequencer, counter, two lanes and accumulator
`timescale 1ns/1ps
`default_nettype none

module dot_engine_top (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    ena,
   input  logic                    start,
   input  dot_ctrl_pkg::beat_cnt_t burst_len,
   input  dot_types_pkg::acc_t     acc_init,
   input  dot_types_pkg::vec_t     a_in,
   input  dot_types_pkg::vec_t     b_in,
   output logic                    busy,
   output logic                    done,
   output dot_types_pkg::acc_t     result
);

   // Sequencer to counter
   logic                    cnt_load;
   dot_ctrl_pkg::beat_cnt_t cnt_value;
   logic                    cnt_dec;
   logic                    cnt_last;

   // Sequencer to datapath
   logic acc_load;
   logic beat_valid;

   // Lane inputs and outputs
   dot_types_pkg::half_beat_t beat_lo;
   dot_types_pkg::half_beat_t beat_hi;
   dot_types_pkg::half_sum_t  sum_lo;
   dot_types_pkg::half_sum_t  sum_hi;
   logic                      sum_lo_valid;

   // ------------------------------------------------------------------
   // Control
   // ------------------------------------------------------------------

   dot_seq_fsm seq0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .ena        (ena),
      .start      (start),
      .burst_len  (burst_len),
      .last       (cnt_last),
      .cnt_load   (cnt_load),
      .cnt_value  (cnt_value),
      .cnt_dec    (cnt_dec),
      .acc_load   (acc_load),
      .beat_valid (beat_valid),
      .busy       (busy),
      .done       (done)
   );

   beat_counter cnt0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .load       (cnt_load),
      .load_value (cnt_value),
      .dec        (cnt_dec),
      .last       (cnt_last)
   );

   // ------------------------------------------------------------------
   // Datapath
   // ------------------------------------------------------------------

   // Elements 0 to 15 go low, elements 16 to 31 go high
   assign beat_lo.valid = beat_valid;
   assign beat_lo.a     = a_in[dot_types_pkg::HALF_W-1:0];
   assign beat_lo.b     = b_in[dot_types_pkg::HALF_W-1:0];
   assign beat_hi.valid = beat_valid;
   assign beat_hi.a     = a_in[dot_types_pkg::HALVES*dot_types_pkg::HALF_W-1:dot_types_pkg::HALF_W];
   assign beat_hi.b     = b_in[dot_types_pkg::HALVES*dot_types_pkg::HALF_W-1:dot_types_pkg::HALF_W];

   dot_half_lane lane_lo0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .ena       (ena),
      .beat      (beat_lo),
      .sum       (sum_lo),
      .sum_valid (sum_lo_valid)
   );

   // The high lane moves in lockstep with the low one and its valid stays open
   dot_half_lane lane_hi0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .ena       (ena),
      .beat      (beat_hi),
      .sum       (sum_hi),
      .sum_valid ()
   );

   // Both lanes see the same beats so the low valid stands for both
   dot_accumulator acc0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .ena      (ena),
      .acc_load (acc_load),
      .acc_init (acc_init),
      .lo_sum   (sum_lo),
      .lo_valid (sum_lo_valid),
      .hi_sum   (sum_hi),
      .result   (result)
   );

endmodule

`default_nettype wire

/* src/dot_seq_fsm.sv */
// Burst sequencer FSM that accepts start, issues beats, drains and pulses done
`timescale 1ns/1ps
`default_nettype none

module dot_seq_fsm (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    ena,
   input  logic                    start,
   input  dot_ctrl_pkg::beat_cnt_t burst_len,
   input  logic                    last,
   output logic                    cnt_load,
   output dot_ctrl_pkg::beat_cnt_t cnt_value,
   output logic                    cnt_dec,
   output logic                    acc_load,
   output logic                    beat_valid,
   output logic                    busy,
   output logic                    done
);

   dot_ctrl_pkg::ctrl_state_e state_q;
   dot_ctrl_pkg::ctrl_state_e state_d;
   logic                      done_d;
   logic                      done_q;

   // ------------------------------------------------------------------
   // Next state logic
   // ------------------------------------------------------------------

   always_comb begin
      state_d   = state_q;
      cnt_load  = 1'b0;
      cnt_value = '0;
      cnt_dec   = 1'b0;
      acc_load  = 1'b0;
      done_d    = 1'b0;
      case (state_q)
         dot_ctrl_pkg::IDLE: begin
            // A zero-length burst has nothing to do and is dropped
            if (start && (burst_len != '0)) begin
               state_d   = dot_ctrl_pkg::RUN;
               cnt_load  = 1'b1;
               cnt_value = burst_len;
               acc_load  = 1'b1;
            end
         end
         dot_ctrl_pkg::RUN: begin
            // Each enabled cycle consumes one vector pair
            if (ena) begin
               cnt_dec = 1'b1;
               if (last) begin
                  // Reuse the counter to time the pipeline drain
                  state_d   = dot_ctrl_pkg::DRAIN;
                  cnt_load  = 1'b1;
                  cnt_value = dot_ctrl_pkg::DRAIN_BEATS;
               end
            end
         end
         dot_ctrl_pkg::DRAIN: begin
            if (ena) begin
               cnt_dec = 1'b1;
               if (last) begin
                  state_d = dot_ctrl_pkg::IDLE;
                  done_d  = 1'b1;
               end
            end
         end
         default: begin
            state_d = dot_ctrl_pkg::IDLE;
         end
      endcase
   end

   // ------------------------------------------------------------------
   // State and done registers
   // ------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= dot_ctrl_pkg::IDLE;
         done_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         done_q  <= done_d;
      end
   end

   // Beats are offered for the whole RUN state, ena decides when they count
   assign beat_valid = (state_q == dot_ctrl_pkg::RUN);
   assign busy       = (state_q != dot_ctrl_pkg::IDLE);
   assign done       = done_q;

endmodule

`default_nettype wire

/* src/beat_counter.sv */
// Loadable down-counter for burst and drain beats with a registered last flag
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    load,
   input  dot_ctrl_pkg::beat_cnt_t load_value,
   input  logic                    dec,
   output logic                    last
);

   dot_ctrl_pkg::beat_cnt_t count_q;
   logic                    last_q;

   // ------------------------------------------------------------------
   // Counter
   // ------------------------------------------------------------------

   // Load has priority, so the sequencer can reload on the final beat
   // The last flag is computed from the value the count is about to take
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count_q <= '0;
         last_q  <= 1'b0;
      end else if (load) begin
         count_q <= load_value;
         last_q  <= (load_value == dot_ctrl_pkg::beat_cnt_t'(1));
      end else if (dec && (count_q != '0)) begin
         count_q <= count_q - dot_ctrl_pkg::beat_cnt_t'(1);
         // Stepping down from two lands on one
         last_q  <= (count_q == dot_ctrl_pkg::beat_cnt_t'(2));
      end
   end

   // High while the count equals one
   assign last = last_q;

endmodule

`default_nettype wire

/* src/dot_accumulator.sv */
// Split-half accumulator that loads an initial value and adds both lane sums
`timescale 1ns/1ps
`default_nettype none

module dot_accumulator (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     ena,
   input  logic                     acc_load,
   input  dot_types_pkg::acc_t      acc_init,
   input  dot_types_pkg::half_sum_t lo_sum,
   input  logic                     lo_valid,
   input  dot_types_pkg::half_sum_t hi_sum,
   output dot_types_pkg::acc_t      result
);

   dot_types_pkg::acc_t result_q;

   // Current halves of the accumulator
   dot_types_pkg::half_sum_t lo_cur;
   dot_types_pkg::half_sum_t hi_cur;

   // Next halves, each one wraps on its own
   dot_types_pkg::half_sum_t lo_next;
   dot_types_pkg::half_sum_t hi_next;

   assign lo_cur = result_q[dot_types_pkg::SUM_W-1:0];
   assign hi_cur = result_q[dot_types_pkg::ACC_W-1:dot_types_pkg::SUM_W];

   // No carry passes from the low half into the high half
   assign lo_next = lo_cur + lo_sum;
   assign hi_next = hi_cur + hi_sum;

   // ------------------------------------------------------------------
   // Accumulator register
   // ------------------------------------------------------------------

   // A load from the sequencer wins over any sum still arriving
   // Both lanes run in lockstep so the low valid stands for both
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result_q <= '0;
      end else if (acc_load) begin
         result_q <= acc_init;
      end else if (ena && lo_valid) begin
         result_q <= {hi_next, lo_next};
      end
   end

   assign result = result_q;

endmodule

`default_nettype wire

/* src/dot_half_lane.sv */
// Sixteen-lane multiplier with registered adder tree and valid pipeline
`timescale 1ns/1ps
`default_nettype none

module dot_half_lane (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      ena,
   input  dot_types_pkg::half_beat_t beat,
   output dot_types_pkg::half_sum_t  sum,
   output logic                      sum_valid
);

   // One valid bit per register stage, oldest at the top
   logic [dot_types_pkg::LANE_STAGES-1:0] valid_q;

   // Stage one holds the raw element pairs
   dot_types_pkg::half_vec_t a_q;
   dot_types_pkg::half_vec_t b_q;

   // Stage two holds the sixteen products
   dot_types_pkg::prod_t prod_d [dot_types_pkg::LANES];
   dot_types_pkg::prod_t prod_q [dot_types_pkg::LANES];

   // Stage three holds the wrapped sum
   dot_types_pkg::half_sum_t tree_sum;
   dot_types_pkg::half_sum_t sum_q;

   // ------------------------------------------------------------------
   // Valid pipeline
   // ------------------------------------------------------------------

   // The valid bit shifts only on enabled cycles so it stays with its data
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
      end else if (ena) begin
         valid_q <= {valid_q[dot_types_pkg::LANE_STAGES-2:0], beat.valid};
      end
   end

   // ------------------------------------------------------------------
   // Input register
   // ------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (ena) begin
         a_q <= beat.a;
         b_q <= beat.b;
      end
   end

   // ------------------------------------------------------------------
   // Multipliers
   // ------------------------------------------------------------------

   // Each lane picks its element pair out of the packed half vectors
   for (genvar i = 0; i < dot_types_pkg::LANES; i++) begin : g_mul
      dot_types_pkg::elem_t a_e;
      dot_types_pkg::elem_t b_e;

      assign a_e = a_q[i*dot_types_pkg::ELEM_W +: dot_types_pkg::ELEM_W];
      assign b_e = b_q[i*dot_types_pkg::ELEM_W +: dot_types_pkg::ELEM_W];
      // An 8 by 8 unsigned product always fits in 16 bits
      assign prod_d[i] = dot_types_pkg::prod_t'(a_e) * dot_types_pkg::prod_t'(b_e);
   end

   always_ff @(posedge clk) begin
      if (ena) begin
         prod_q <= prod_d;
      end
   end

   // ------------------------------------------------------------------
   // Adder tree
   // ------------------------------------------------------------------

   // Sixteen products reduce to one sum, carries above bit 15 are dropped
   always_comb begin
      tree_sum = '0;
      for (int i = 0; i < dot_types_pkg::LANES; i++) begin
         tree_sum = tree_sum + prod_q[i];
      end
   end

   always_ff @(posedge clk) begin
      if (ena) begin
         sum_q <= tree_sum;
      end
   end

   assign sum = sum_q;
   // The last valid stage lines up with the tree-sum register
   assign sum_valid = valid_q[dot_types_pkg::LANE_STAGES-1];

endmodule

`default_nettype wire

/* src/dot_ctrl_pkg.sv */
// Control package with the sequencer state enum, beat count type and drain length
`default_nettype none

package dot_ctrl_pkg;

   // Width of the burst and drain counter
   localparam int CNT_W = 8;

   typedef logic [CNT_W-1:0] beat_cnt_t;

   // The accumulator adds one register after the lane pipeline
   localparam int ACC_STAGES = 1;

   // Enabled cycles after the last beat until the final sum has landed
   localparam beat_cnt_t DRAIN_BEATS = beat_cnt_t'(dot_types_pkg::LANE_STAGES + ACC_STAGES);

   // ------------------------------------------------------------------
   // Sequencer states
   // ------------------------------------------------------------------

   // IDLE waits for start, RUN takes beats and DRAIN empties the pipeline
   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DRAIN
   } ctrl_state_e;

endpackage

`default_nettype wire

/* src/dot_types_pkg.sv */
// Datapath package with element widths, vector typedefs and the half-beat struct
`default_nettype none

package dot_types_pkg;

   // ------------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------------

   // Width of one unsigned vector element
   localparam int ELEM_W = 8;
   // Products and half sums keep twice the element width and wrap there
   localparam int PROD_W = 2 * ELEM_W;
   localparam int SUM_W = PROD_W;
   // Element pairs handled by one dot_half_lane
   localparam int LANES = 16;
   // The vector splits into a low and a high half
   localparam int HALVES = 2;
   // Input, product and tree-sum registers inside a lane
   localparam int LANE_STAGES = 3;
   localparam int HALF_W = LANES * ELEM_W;
   localparam int ACC_W = HALVES * SUM_W;

   // ------------------------------------------------------------------
   // Types
   // ------------------------------------------------------------------

   typedef logic [ELEM_W-1:0] elem_t;
   typedef logic [PROD_W-1:0] prod_t;
   typedef logic [SUM_W-1:0] half_sum_t;
   typedef logic [ACC_W-1:0] acc_t;
   // Element i sits in bits 8i+7 down to 8i
   typedef logic [HALVES*HALF_W-1:0] vec_t;
   typedef logic [HALF_W-1:0] half_vec_t;

   // One beat as seen by a single lane
   typedef struct packed {
      logic      valid;
      half_vec_t a;
      half_vec_t b;
   } half_beat_t;

endpackage

`default_nettype wire
